// ==== hdl/sump_pkg.sv ====
package sump_pkg;

  ////////////////////////////////////////
  // Serial timing
  ////////////////////////////////////////

  localparam int clks_per_bit = 16;                     // Small for fast sim
  localparam int cyc_w        = $clog2(clks_per_bit);
  localparam logic [cyc_w-1:0] cyc_last = cyc_w'(clks_per_bit - 1);   // End of one bit
  localparam logic [cyc_w-1:0] cyc_half = cyc_w'(clks_per_bit / 2 - 1); // Mid start bit
  localparam int frame_bits   = 10;                     // Start, 8 data, stop

  ////////////////////////////////////////
  // Opcodes and link types
  ////////////////////////////////////////

  typedef enum logic [7:0] {
    op_reset    = 8'h00,
    op_run      = 8'h01,
    op_id       = 8'h02,
    op_metadata = 8'h04,
    op_xon      = 8'h11,
    op_xoff     = 8'h13
  } sump_opcode_e;

  typedef enum logic {reply_id, reply_metadata} reply_kind_e;

  typedef struct packed {
    reply_kind_e kind;                                  // Which table to play back
  } reply_req_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;                                   // Final byte of a reply
  } tx_beat_t;

  ////////////////////////////////////////
  // Reply tables, first byte in the MSBs
  ////////////////////////////////////////

  localparam int ptr_w    = 6;                          // Covers the longer table
  localparam int id_len   = 4;
  localparam int meta_len = 50;
  localparam logic [ptr_w-1:0] id_last   = ptr_w'(id_len - 1);
  localparam logic [ptr_w-1:0] meta_last = ptr_w'(meta_len - 1);

  localparam logic [8*id_len-1:0] id_table = {"1", "A", "L", "S"};

  // Offset  Record
  //  0      0x01 device name, 27 chars + 0x00
  // 29      0x02 firmware "1.00" + 0x00
  // 35      0x21 sample memory, 24576
  // 40      0x23 max sample rate, 200 MHz
  // 45      0x40 probe count
  // 47      0x41 protocol version
  // 49      0x00 end of metadata
  localparam logic [8*meta_len-1:0] meta_table = {
    8'h01, "SUMP Logic Analyzer Link v1", 8'h00,
    8'h02, "1.00", 8'h00,
    8'h21, 8'h00, 8'h00, 8'h60, 8'h00,                  // Big-endian 32 bit
    8'h23, 8'h0b, 8'heb, 8'hc2, 8'h00,
    8'h40, 8'h08,
    8'h41, 8'h02,
    8'h00
  };

endpackage

// ==== hdl/uart_rx.sv ====
module uart_rx import sump_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_data
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

  rx_state_e        state;
  logic             rx_meta;                            // First sync stage
  logic             rx_sync;                            // Safe to use
  logic [cyc_w-1:0] cyc;                                // Cycles within a bit
  logic [2:0]       bit_idx;                            // Data bit number
  logic [7:0]       shreg;                              // LSB arrives first

  // Line idles high, so sync flops come out of reset high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      cyc      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;                                 // Pulse only
      case (state)
        st_idle: begin
          cyc <= '0;
          if (!rx_sync) state <= st_start;              // Falling start edge
        end
        st_start: begin
          if (cyc == cyc_half) begin
            cyc     <= '0;
            bit_idx <= '0;
            // Glitch if the line is already back high
            state   <= rx_sync ? st_idle : st_data;
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        st_data: begin
          if (cyc == cyc_last) begin                    // Mid data bit
            cyc <= '0;
            if (bit_idx == 3'd7) state <= st_stop;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        st_stop: begin
          if (cyc == cyc_last) begin                    // Mid stop bit
            cyc      <= '0;
            rx_valid <= rx_sync;                        // Low stop bit drops the frame
            state    <= st_idle;
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Shift in at each data bit centre
  always_ff @(posedge clock) begin
    if (state == st_data && cyc == cyc_last) shreg <= {rx_sync, shreg[7:1]};
  end

  assign rx_data = shreg;

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx import sump_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     beat_valid,
  output logic     beat_ready,
  input  tx_beat_t beat,
  output logic     tx
);

  typedef enum logic {st_idle, st_shift} tx_state_e;

  tx_state_e             state;
  logic [frame_bits-1:0] frame;                         // Bit 0 is on the wire
  logic [cyc_w-1:0]      cyc;                           // Cycles within a bit
  logic [3:0]            bit_idx;                       // Bit of the frame

  ////////////////////////////////////////
  // Shift FSM
  ////////////////////////////////////////

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      frame   <= '1;                                    // Line idle high
      cyc     <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (beat_valid) begin
            // Stop, data LSB first, start
            frame   <= {1'b1, beat.data, 1'b0};
            cyc     <= '0;
            bit_idx <= '0;
            state   <= st_shift;
          end
        end
        st_shift: begin
          if (cyc == cyc_last) begin
            cyc   <= '0;
            frame <= {1'b1, frame[frame_bits-1:1]};   // Refill with idle level
            if (bit_idx == 4'(frame_bits - 1)) begin
              state <= st_idle;                         // Stop bit done
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // beat.last has no meaning on the wire
  assign beat_ready = (state == st_idle);
  assign tx         = frame[0];

endmodule

// ==== hdl/sump_cmd_decoder.sv ====
module sump_cmd_decoder import sump_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  output logic       req_valid,
  input  logic       req_ready,
  output reply_req_t req
);

  typedef enum logic {st_opcode, st_param} dec_state_e;

  dec_state_e  state;
  logic [1:0]  param_cnt;                               // Four parameter bytes
  logic        is_query;
  reply_kind_e query_kind;
  logic        accept;

  // Only the two queries are of interest
  always_comb begin
    is_query   = 1'b0;
    query_kind = reply_id;
    case (rx_data)
      op_id:       is_query = 1'b1;
      op_metadata: begin
        is_query   = 1'b1;
        query_kind = reply_metadata;
      end
      default:     is_query = 1'b0;                     // Reset and flow control too
    endcase
  end

  // Sender not ready means a reply is running, so the query is lost
  assign accept = rx_valid && (state == st_opcode) && is_query && !req_valid && req_ready;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= st_opcode;
      param_cnt <= '0;
      req_valid <= 1'b0;
    end else begin
      if (req_valid && req_ready) req_valid <= 1'b0;   // Transfer
      if (accept) req_valid <= 1'b1;
      if (rx_valid) begin
        case (state)
          st_opcode: begin
            param_cnt <= '0;
            if (rx_data[7]) state <= st_param;          // Long command
          end
          st_param: begin
            param_cnt <= param_cnt + 1'b1;
            if (param_cnt == 2'd3) state <= st_opcode;
          end
          default: state <= st_opcode;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) req.kind <= query_kind;
  end

endmodule

// ==== hdl/metadata_sender.sv ====
module metadata_sender import sump_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid,
  output logic       req_ready,
  input  reply_req_t req,
  output logic       beat_valid,
  input  logic       beat_ready,
  output tx_beat_t   beat,
  output logic       reply_busy
);

  typedef enum logic {st_idle, st_send} snd_state_e;

  snd_state_e       state;
  reply_kind_e      kind;                               // Latched at request
  logic [ptr_w-1:0] ptr;                                // Byte within reply
  logic [7:0]       id_byte;
  logic [7:0]       meta_byte;
  logic             at_last;
  logic             beat_done;

  ////////////////////////////////////////
  // Table lookup
  ////////////////////////////////////////

  // Tables are packed with the first byte at the top
  always_comb begin
    id_byte   = id_table[8*(id_len - 1 - ptr[1:0]) +: 8];    // Four ID bytes
    meta_byte = meta_table[8*(meta_len - 1 - ptr) +: 8];
  end

  always_comb begin
    if (kind == reply_id) begin
      at_last = (ptr == id_last);
    end else begin
      at_last = (ptr == meta_last);
    end
  end

  assign beat.data = (kind == reply_id) ? id_byte : meta_byte;
  assign beat.last = at_last;

  ////////////////////////////////////////
  // Reply FSM
  ////////////////////////////////////////

  assign beat_valid = (state == st_send);
  assign beat_done  = beat_valid && beat_ready;
  assign req_ready  = (state == st_idle);               // Never queue requests
  assign reply_busy = (state == st_send);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
      kind  <= reply_id;
      ptr   <= '0;
    end else begin
      case (state)
        st_idle: begin
          ptr <= '0;
          if (req_valid) begin                          // Ready is high here
            kind  <= req.kind;
            state <= st_send;
          end
        end
        st_send: begin
          if (beat_done) begin
            if (at_last) begin
              state <= st_idle;
            end else begin
              ptr <= ptr + 1'b1;                        // Next byte next cycle
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== hdl/sump_link_top.sv ====
module sump_link_top import sump_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic rx,
  output logic tx,
  output logic reply_busy
);

  logic       rx_valid;                                 // Pulse, no ready
  logic [7:0] rx_data;
  logic       req_valid;
  logic       req_ready;
  reply_req_t req;
  logic       beat_valid;
  logic       beat_ready;
  tx_beat_t   beat;

  // Host bytes in
  uart_rx u_rx (
    .clock(clock), .reset(reset),
    .rx(rx), .rx_valid(rx_valid), .rx_data(rx_data)
  );

  sump_cmd_decoder u_dec (
    .clock(clock), .reset(reset),
    .rx_valid(rx_valid), .rx_data(rx_data),
    .req_valid(req_valid), .req_ready(req_ready), .req(req)
  );

  // Reply engine, stalls the decoder for a whole reply
  metadata_sender u_snd (
    .clock(clock), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat),
    .reply_busy(reply_busy)
  );

  uart_tx u_tx (
    .clock(clock), .reset(reset),
    .beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat),
    .tx(tx)
  );

endmodule

// ==== bench/sump_link_sva.sv ====
module sump_link_sva import sump_pkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     req_valid,
  input logic     req_ready,
  input logic     reply_busy,
  input logic     beat_valid,
  input logic     beat_ready,
  input tx_beat_t beat
);

  logic last_done;                                      // Final beat leaves

  assign last_done = beat_valid && beat_ready && beat.last;

  // Stalled beat must hold until the transmitter takes it
  a_beat_hold: assert property (@(posedge clock) disable iff (reset)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat))
    else $error("beat dropped or changed while stalled");

  // Accepted request opens a reply on the next cycle
  a_req_starts_reply: assert property (@(posedge clock) disable iff (reset)
    req_valid && req_ready |=> reply_busy && beat_valid)
    else $error("request taken but no reply started");

  // No new request until the last byte has gone
  a_no_req_when_busy: assert property (@(posedge clock) disable iff (reset)
    reply_busy && !last_done |=> reply_busy && !req_ready)
    else $error("req_ready high during a reply");

  // Reply closes right after its last beat
  a_idle_after_last: assert property (@(posedge clock) disable iff (reset)
    last_done |=> !reply_busy && !beat_valid)
    else $error("beat_valid high after the last beat");

endmodule

bind metadata_sender sump_link_sva u_sva (
  .clock(clock), .reset(reset),
  .req_valid(req_valid), .req_ready(req_ready), .reply_busy(reply_busy),
  .beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat)
);

// ==== bench/sump_link_tb.sv ====
module sump_link_tb import sump_pkg::*; ();

  logic clock;
  logic reset;
  logic rx;
  logic tx;
  logic reply_busy;

  int         errors;
  int         tests_run;
  int         tests_failed;
  integer     seed;
  logic [7:0] id_exp[$];                                // Expected replies
  logic [7:0] meta_exp[$];

  sump_link_top dut (
    .clock(clock), .reset(reset), .rx(rx), .tx(tx), .reply_busy(reply_busy)
  );

  always #20 clock = ~clock;                            // Period 40

  ////////////////////////////////////////
  // Expected reply bytes
  ////////////////////////////////////////

  task push_be32(input logic [31:0] value);
    for (int i = 3; i >= 0; i--) meta_exp.push_back(value[8*i +: 8]);   // MSB first
  endtask

  task push_text(input string text);
    for (int i = 0; i < text.len(); i++) meta_exp.push_back(text[i]);
    meta_exp.push_back(8'h00);                          // Zero terminated
  endtask

  task build_expected;
    id_exp = '{"1", "A", "L", "S"};
    meta_exp.delete();
    meta_exp.push_back(8'h01);                          // Device name
    push_text("SUMP Logic Analyzer Link v1");
    meta_exp.push_back(8'h02);                          // Firmware version
    push_text("1.00");
    meta_exp.push_back(8'h21);                          // Sample memory
    push_be32(32'd24576);
    meta_exp.push_back(8'h23);                          // Max sample rate
    push_be32(32'd200000000);
    meta_exp.push_back(8'h40);                          // Probe count
    meta_exp.push_back(8'h08);
    meta_exp.push_back(8'h41);                          // Protocol version
    meta_exp.push_back(8'h02);
    meta_exp.push_back(8'h00);                          // End of metadata
  endtask

  ////////////////////////////////////////
  // Host side serial model
  ////////////////////////////////////////

  task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};                            // Stop, data, start
    for (int i = 0; i < 10; i++) begin
      @(negedge clock) rx = frame[i];
      repeat (clks_per_bit - 1) @(negedge clock);
    end
  endtask

  task get_byte(input string name, output logic [7:0] data, output bit ok);
    int limit;
    bit found;
    limit = 40 * clks_per_bit;                          // 40 bit periods
    found = 1'b0;
    data  = '0;
    for (int cnt = 0; cnt < limit && !found; cnt++) begin
      @(negedge clock);
      if (tx === 1'b0) found = 1'b1;
    end
    ok = found;
    if (!found) begin
      $display("%s: timed out waiting for a start bit on tx", name);
      errors++;
    end else begin
      repeat (clks_per_bit / 2) @(negedge clock);      // Mid start bit
      check({name, " start bit"}, 0, tx);
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clock);
        data[i] = tx;                                   // LSB first
      end
      repeat (clks_per_bit) @(negedge clock);
      check({name, " stop bit"}, 1, tx);
    end
  endtask

  // Line and busy flag must stay quiet for the whole window
  task expect_silence(input string name, input int bits);
    bit bad;
    bad = 1'b0;
    for (int cnt = 0; cnt < bits * clks_per_bit && !bad; cnt++) begin
      @(negedge clock);
      if (tx !== 1'b1) begin
        $display("%s: unexpected start bit on tx", name);
        bad = 1'b1;
      end else if (reply_busy !== 1'b0) begin
        $display("%s: reply_busy went high", name);
        bad = 1'b1;
      end
    end
    if (bad) errors++;
  endtask

  task receive_reply(input string name, input bit is_meta);
    logic [7:0] got;
    bit ok;
    int n;
    n = is_meta ? meta_exp.size() : id_exp.size();
    for (int i = 0; i < n; i++) begin
      get_byte(name, got, ok);
      if (!ok) break;                                   // Avoid a timeout per byte
      check(name, is_meta ? meta_exp[i] : id_exp[i], got);
      // Last beat not taken yet
      if (i < n - 1) check({name, " busy"}, 1, reply_busy);
    end
  endtask

  task report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task idle_after_reset;
    int e0;
    e0 = errors;
    check("idle_after_reset tx", 1, tx);
    check("idle_after_reset busy", 0, reply_busy);
    expect_silence("idle_after_reset", 20);
    report_test("idle_after_reset", e0);
  endtask

  task id_reply;
    int e0;
    e0 = errors;
    fork
      send_byte(op_id);
      receive_reply("id_reply", 1'b0);
    join
    expect_silence("id_reply", 20);
    report_test("id_reply", e0);
  endtask

  task metadata_reply;
    int e0;
    e0 = errors;
    fork
      send_byte(op_metadata);
      receive_reply("metadata_reply", 1'b1);
    join
    expect_silence("metadata_reply", 20);
    report_test("metadata_reply", e0);
  endtask

  task long_command_skip;
    int e0;
    e0 = errors;
    fork
      begin
        send_byte(8'h82);                               // Params look like queries
        send_byte(8'h02);
        send_byte(8'h04);
        send_byte(8'h02);
        send_byte(8'h04);
      end
      expect_silence("long_command_skip", 70);
    join
    fork
      send_byte(op_id);
      receive_reply("long_command_skip id", 1'b0);
    join
    expect_silence("long_command_skip", 20);
    report_test("long_command_skip", e0);
  endtask

  task short_commands_ignored;
    int e0;
    logic [7:0] filler[5];
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      filler[i] = 8'($random(seed)) & 8'h7f;           // Short opcode only
      if (filler[i] == 8'h02 || filler[i] == 8'h04) filler[i] = filler[i] ^ 8'h40;
    end
    fork
      begin
        send_byte(op_reset);
        send_byte(op_run);
        send_byte(op_xon);
        send_byte(op_xoff);
        for (int i = 0; i < 5; i++) send_byte(filler[i]);
      end
      expect_silence("short_commands_ignored", 110);  // Covers all 9 frames
    join
    report_test("short_commands_ignored", e0);
  endtask

  // Second query lands while the metadata streams
  task query_during_reply;
    int e0;
    e0 = errors;
    fork
      begin
        send_byte(op_metadata);
        send_byte(op_id);
      end
      receive_reply("query_during_reply", 1'b1);
    join
    expect_silence("query_during_reply", 30);
    report_test("query_during_reply", e0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    rx           = 1'b1;                                // Idle line
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 53;
    build_expected();
    repeat (3) @(negedge clock);
    reset = 1'b0;

    idle_after_reset();
    id_reply();
    metadata_reply();
    long_command_skip();
    short_commands_ignored();
    query_during_reply();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hdl/sump_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/sump_cmd_decoder.sv
hdl/metadata_sender.sv
hdl/sump_link_top.sv
bench/sump_link_sva.sv
bench/sump_link_tb.sv
